// ==== flist.f ====
verilog/nnFormatPkg.sv
verilog/axiLiteRegPkg.sv
verilog/reluNeuron.sv
verilog/denseLayer.sv
verilog/axiLiteRegs.sv
verilog/mlpAccelTop.sv
verification/mlpAccelTb.sv

// ==== verification/mlpAccelTb.sv ====
`timescale 1ns/1ps

module mlpAccelTb
	import nnFormatPkg::*, axiLiteRegPkg::*;
();

	localparam int WaitLimit = 50;
	localparam int PollLimit = 20;
	localparam logic [31:0] Seed = 32'h8b349d9a;

	// Neuron 3 first, highest input first. 8'h80 is a weight of -128
	localparam logic [HiddenCount*InputCount*DataWidth-1:0] NetHiddenWeights = {
		8'sd3, -8'sd2, 8'sd9, 8'sd1, -8'sd6, 8'sd11, 8'sd0, 8'sd4, -8'sd8, 8'sd7,
		-8'sd12, 8'sd33, 8'sd0, 8'sd5, 8'sd19, -8'sd40, 8'sd2, 8'sd0, 8'sd21, 8'sd6,
		8'sd0, 8'sd0, 8'sd0, 8'sd0, 8'sd0, 8'sd0, 8'sd1, 8'sd64, 8'sd0, 8'sd0,
		8'sd4, -8'sd9, 8'sd15, -8'sd3, 8'sd7, 8'sd2, -8'sd10, 8'sd6, 8'h80, 8'sd127
	};
	localparam logic [HiddenCount*BiasWidth-1:0] NetHiddenBiases = {
		16'sd40, -16'sd200, -16'sd16, -16'sd1000
	};
	// Output 1 copies hidden neuron 1, so the rounding of that neuron shows up directly
	localparam logic [OutputCount*HiddenCount*DataWidth-1:0] NetOutputWeights = {
		8'sd0, 8'sd0, 8'sd64, 8'sd0,
		-8'sd5, 8'sd20, 8'h80, 8'sd127
	};
	localparam logic [OutputCount*BiasWidth-1:0] NetOutputBiases = {16'sd0, -16'sd300};

	logic clk = 1'b0;
	logic reset;
	logic [AddrWidth-1:0] awaddr, araddr;
	logic awvalid, awready, wvalid, wready, bvalid, bready;
	logic arvalid, arready, rvalid, rready;
	logic [BusWidth-1:0] wdata, rdata;
	logic [BusWidth/8-1:0] wstrb;
	logic [1:0] bresp, rresp;
	int errorCount = 0;
	int checkCount = 0;

	// Byte 9 first. Hidden neuron 1 sees 64 * input 2 + input 3 - 16
	logic [InputCount*DataWidth-1:0] stimTable [7] = '{
		80'h0,
		80'h7f7f7f7f7f7f7f7f7f7f,
		80'h80808080808080808080,
		80'h0000_0000_0000_300a_0000,
		80'h0000_0000_0000_317e_0000,
		80'h0000_0000_0000_317f_0000,
		80'h05f0_229c_4107_1230_807f
	};

	mlpAccelTop #(
		.HiddenWeights(NetHiddenWeights),
		.HiddenBiases(NetHiddenBiases),
		.OutputWeights(NetOutputWeights),
		.OutputBiases(NetOutputBiases)
	) DUT (
		.clk(clk), .reset(reset),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready)
	);

	always #20 clk = ~clk;

	function automatic int activate(input int acc);
		int level;
		if (acc < 0)
			return 0;
		if (acc >= (ActMax + 1) << FracBits)
			return ActMax;
		level = acc >> FracBits;
		// Only a remainder above one half rounds up
		if (acc % (1 << FracBits) > (1 << (FracBits - 1)))
			level++;
		if (level > ActMax)
			level = ActMax;
		return level;
	endfunction

	function automatic logic [OutputCount*DataWidth-1:0] modelNetwork(
		input logic [InputCount*DataWidth-1:0] x);
		int acc;
		int act;
		int w;
		int hidden [HiddenCount];
		logic [OutputCount*DataWidth-1:0] y;
		for (int n = 0; n < HiddenCount; n++)
		begin
			acc = signed'(NetHiddenBiases[n*BiasWidth +: BiasWidth]);
			for (int i = 0; i < InputCount; i++)
			begin
				act = signed'(x[i*DataWidth +: DataWidth]);
				w = signed'(NetHiddenWeights[(n*InputCount + i)*DataWidth +: DataWidth]);
				acc += act * w;
			end
			hidden[n] = activate(acc);
		end
		for (int n = 0; n < OutputCount; n++)
		begin
			acc = signed'(NetOutputBiases[n*BiasWidth +: BiasWidth]);
			for (int i = 0; i < HiddenCount; i++)
			begin
				w = signed'(NetOutputWeights[(n*HiddenCount + i)*DataWidth +: DataWidth]);
				acc += hidden[i] * w;
			end
			y[n*DataWidth +: DataWidth] = DataWidth'(activate(acc));
		end
		return y;
	endfunction

	task automatic abortRun(input string what);
		errorCount++;
		$display("Timeout: %s", what);
		$display("Checks run: %0d, errors: %0d", checkCount, errorCount);
		$display("Testbench failed");
		$finish;
	endtask

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checkCount++;
		if (actual !== expected)
		begin
			errorCount++;
			$display("** Error %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	// All bus tasks start and end 2 ns after a rising edge
	task automatic axiWrite(input logic [AddrWidth-1:0] addr, input logic [31:0] data,
		input int holdCycles, output logic [1:0] resp);
		int waited;
		awaddr = addr;
		wdata = data;
		awvalid = 1'b1;
		wvalid = 1'b1;
		waited = 0;
		// Ready follows valid within the same cycle
		#1;
		while (!awready)
		begin
			@(posedge clk);
			#3;
			waited++;
			if (waited > WaitLimit)
				abortRun("awready never rose");
		end
		checkValue("wready", 32'h1, wready);
		@(posedge clk);
		#2;
		checkValue("awready", 32'h0, awready);
		checkValue("wready", 32'h0, wready);
		awvalid = 1'b0;
		wvalid = 1'b0;
		waited = 0;
		while (!bvalid)
		begin
			@(posedge clk);
			#2;
			waited++;
			if (waited > WaitLimit)
				abortRun("bvalid never rose");
		end
		resp = bresp;
		for (int c = 0; c < holdCycles; c++)
		begin
			@(posedge clk);
			#2;
			if (!bvalid)
			begin
				errorCount++;
				$display("bvalid fell while bready was still low");
			end
			checkValue("bresp held", resp, bresp);
		end
		bready = 1'b1;
		@(posedge clk);
		#2;
		bready = 1'b0;
		if (bvalid)
		begin
			errorCount++;
			$display("bvalid stayed high after the write response was taken");
		end
	endtask

	task automatic axiRead(input logic [AddrWidth-1:0] addr, input int holdCycles,
		output logic [31:0] data, output logic [1:0] resp);
		int waited;
		araddr = addr;
		arvalid = 1'b1;
		waited = 0;
		#1;
		while (!arready)
		begin
			@(posedge clk);
			#3;
			waited++;
			if (waited > WaitLimit)
				abortRun("arready never rose");
		end
		@(posedge clk);
		#2;
		checkValue("arready", 32'h0, arready);
		arvalid = 1'b0;
		waited = 0;
		while (!rvalid)
		begin
			@(posedge clk);
			#2;
			waited++;
			if (waited > WaitLimit)
				abortRun("rvalid never rose");
		end
		data = rdata;
		resp = rresp;
		for (int c = 0; c < holdCycles; c++)
		begin
			@(posedge clk);
			#2;
			if (!rvalid)
			begin
				errorCount++;
				$display("rvalid fell while rready was still low");
			end
			checkValue("rdata held", data, rdata);
			checkValue("rresp held", resp, rresp);
		end
		rready = 1'b1;
		@(posedge clk);
		#2;
		rready = 1'b0;
		if (rvalid)
		begin
			errorCount++;
			$display("rvalid stayed high after the read data was taken");
		end
	endtask

	task automatic writeChecked(input logic [AddrWidth-1:0] addr, input logic [31:0] data,
		input logic [1:0] expResp, input int holdCycles);
		logic [1:0] resp;
		axiWrite(addr, data, holdCycles, resp);
		checkValue($sformatf("bresp at %h", addr), expResp, resp);
	endtask

	task automatic readChecked(input logic [AddrWidth-1:0] addr, input logic [31:0] expData,
		input logic [1:0] expResp, input int holdCycles);
		logic [31:0] data;
		logic [1:0] resp;
		axiRead(addr, holdCycles, data, resp);
		checkValue($sformatf("rresp at %h", addr), expResp, resp);
		checkValue($sformatf("rdata at %h", addr), expData, data);
	endtask

	task automatic waitDone();
		logic [31:0] data;
		logic [1:0] resp;
		int polls;
		polls = 0;
		axiRead(Status, 0, data, resp);
		while (!data[StatusDoneBit])
		begin
			polls++;
			if (polls > PollLimit)
				abortRun("Status never reported done");
			axiRead(Status, 0, data, resp);
		end
	endtask

	task automatic loadInputs(input logic [InputCount*DataWidth-1:0] x);
		writeChecked(InData0, x[31:0], Okay, 0);
		writeChecked(InData1, x[63:32], Okay, 0);
		writeChecked(InData2, {16'h0, x[79:64]}, Okay, 0);
	endtask

	task automatic runInference(input logic [InputCount*DataWidth-1:0] x);
		loadInputs(x);
		readChecked(InData0, x[31:0], Okay, 0);
		readChecked(InData1, x[63:32], Okay, 0);
		readChecked(InData2, {16'h0, x[79:64]}, Okay, 0);
		writeChecked(Ctrl, 32'h1, Okay, 0);
		waitDone();
		readChecked(Result, {16'h0, modelNetwork(x)}, Okay, 0);
	endtask

	initial
	begin
		logic [InputCount*DataWidth-1:0] vec;
		void'($urandom(Seed));
		reset = 1'b1;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = 4'hf;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		repeat (16) @(posedge clk);
		#2;
		reset = 1'b0;

		readChecked(Status, 32'h0, Okay, 0);
		readChecked(Result, 32'h0, Okay, 0);
		readChecked(InData0, 32'h0, Okay, 0);
		readChecked(InData1, 32'h0, Okay, 0);
		readChecked(InData2, 32'h0, Okay, 0);
		readChecked(Ctrl, 32'h0, Okay, 0);

		foreach (stimTable[k])
			runInference(stimTable[k]);
		repeat (20)
		begin
			vec = {16'($urandom), $urandom, $urandom};
			runInference(vec);
		end

		// The second start lands a cycle before the first result, so it must be dropped
		vec = stimTable[6];
		loadInputs(vec);
		writeChecked(Ctrl, 32'h1, Okay, 0);
		readChecked(Status, 32'h2, Okay, 0);
		writeChecked(InData0, ~vec[31:0], Okay, 0);
		writeChecked(Ctrl, 32'h1, Okay, 0);
		waitDone();
		readChecked(Status, 32'h1, Okay, 0);
		readChecked(Result, {16'h0, modelNetwork(vec)}, Okay, 0);

		writeChecked(Status, 32'hffff_ffff, SlvErr, 0);
		readChecked(Status, 32'h1, Okay, 0);
		writeChecked(Result, 32'hffff_ffff, SlvErr, 0);
		readChecked(Result, {16'h0, modelNetwork(vec)}, Okay, 0);
		writeChecked(8'h20, 32'hffff_ffff, SlvErr, 0);
		readChecked(InData0, ~vec[31:0], Okay, 0);
		readChecked(InData1, vec[63:32], Okay, 0);
		readChecked(InData2, {16'h0, vec[79:64]}, Okay, 0);
		readChecked(8'h20, 32'h0, SlvErr, 0);
		readChecked(8'h1c, 32'h0, SlvErr, 0);

		// Held responses, and an inference that finishes behind a held write response
		writeChecked(InData0, 32'h1234_5678, Okay, 6);
		readChecked(InData0, 32'h1234_5678, Okay, 6);
		writeChecked(Ctrl, 32'h1, Okay, 12);
		readChecked(Status, 32'h1, Okay, 0);
		readChecked(Result, {16'h0, modelNetwork({vec[79:32], 32'h1234_5678})}, Okay, 0);

		$display("Checks run: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

// ==== verilog/axiLiteRegPkg.sv ====
package axiLiteRegPkg;

	localparam int AddrWidth = 8;
	localparam int BusWidth = 32;

	// Byte addresses of the control register map
	typedef enum logic [AddrWidth-1:0]
	{
		InData0 = 8'h00,
		InData1 = 8'h04,
		InData2 = 8'h08,
		Ctrl = 8'h0C,
		Status = 8'h10,
		Result = 8'h14
	} regAddr;

	typedef enum logic [1:0]
	{
		Okay = 2'b00,
		SlvErr = 2'b10
	} axiResp;

	localparam int StatusDoneBit = 0;
	localparam int StatusBusyBit = 1;

endpackage

// ==== verilog/axiLiteRegs.sv ====
`timescale 1ns/1ps

module axiLiteRegs
	import nnFormatPkg::*, axiLiteRegPkg::*;
(
	input logic clk,
	input logic reset,
	input logic [AddrWidth-1:0] awaddr,
	input logic awvalid,
	output logic awready,
	input logic [BusWidth-1:0] wdata,
	input logic [BusWidth/8-1:0] wstrb,
	input logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,
	input logic [AddrWidth-1:0] araddr,
	input logic arvalid,
	output logic arready,
	output logic [BusWidth-1:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready,
	output logic [InputCount*DataWidth-1:0] netInputs,
	output logic inValid,
	input logic [OutputCount*DataWidth-1:0] netOutputs,
	input logic outValid
);

	typedef enum logic {WrIdle, WrResp} writeState;
	typedef enum logic {RdIdle, RdData} readState;

	writeState wrState;
	readState rdState;
	logic busy;
	logic done;
	logic [OutputCount*DataWidth-1:0] resultReg;
	axiResp writeResp;
	axiResp readResp;
	logic [BusWidth-1:0] readData;

	// Address and data are taken together, and only with no response pending
	assign awready = (wrState == WrIdle) && awvalid && wvalid;
	assign wready = awready;
	assign bvalid = (wrState == WrResp);
	assign arready = (rdState == RdIdle) && arvalid;
	assign rvalid = (rdState == RdData);

	// Status and Result are read-only
	always_comb
	begin
		case (regAddr'(awaddr))
			InData0, InData1, InData2, Ctrl: writeResp = Okay;
			default: writeResp = SlvErr;
		endcase
	end

	always_comb
	begin
		readData = '0;
		readResp = Okay;
		case (regAddr'(araddr))
			InData0: readData = netInputs[BusWidth-1:0];
			InData1: readData = netInputs[2*BusWidth-1:BusWidth];
			InData2: readData = BusWidth'(netInputs[InputCount*DataWidth-1:2*BusWidth]);
			Ctrl: readData = '0;
			Status:
			begin
				readData[StatusDoneBit] = done;
				readData[StatusBusyBit] = busy;
			end
			Result: readData = BusWidth'(resultReg);
			default: readResp = SlvErr;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wrState <= WrIdle;
			rdState <= RdIdle;
		end
		else
		begin
			if (wrState == WrIdle && awready)
				wrState <= WrResp;
			else if (wrState == WrResp && bready)
				wrState <= WrIdle;
			if (rdState == RdIdle && arready)
				rdState <= RdData;
			else if (rdState == RdData && rready)
				rdState <= RdIdle;
		end
	end

	always_ff @(posedge clk)
	begin
		if (awready)
			bresp <= writeResp;
		if (arready)
		begin
			rdata <= readData;
			rresp <= readResp;
		end
	end

	// Writes are full-word and wstrb is not decoded
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			netInputs <= '0;
			inValid <= 1'b0;
			busy <= 1'b0;
			done <= 1'b0;
			resultReg <= '0;
		end
		else
		begin
			inValid <= 1'b0;
			if (awready)
			begin
				case (regAddr'(awaddr))
					InData0: netInputs[BusWidth-1:0] <= wdata;
					InData1: netInputs[2*BusWidth-1:BusWidth] <= wdata;
					InData2: netInputs[InputCount*DataWidth-1:2*BusWidth] <=
						wdata[InputCount*DataWidth-2*BusWidth-1:0];
					Ctrl:
					begin
						// A start while busy is acknowledged but dropped
						if (wdata[0] && !busy)
						begin
							busy <= 1'b1;
							done <= 1'b0;
							inValid <= 1'b1;
						end
					end
					default: ;
				endcase
			end
			if (outValid)
			begin
				resultReg <= netOutputs;
				done <= 1'b1;
				busy <= 1'b0;
			end
		end
	end

endmodule

// ==== verilog/denseLayer.sv ====
`timescale 1ns/1ps

module denseLayer
	import nnFormatPkg::*;
#(
	parameter int InputCount = nnFormatPkg::InputCount,
	parameter int NeuronCount = HiddenCount,
	parameter logic [NeuronCount*InputCount*DataWidth-1:0] Weights = '0,
	parameter logic [NeuronCount*BiasWidth-1:0] Biases = '0
)
(
	input logic clk,
	input logic reset,
	input logic [InputCount*DataWidth-1:0] activations,
	input logic inValid,
	output logic [NeuronCount*DataWidth-1:0] outActivations,
	output logic outValid
);

	logic [NeuronLatency-1:0] validPipe;

	// Weights are neuron-major, neuron 0 in the low bits
	for (genvar n = 0; n < NeuronCount; n++)
	begin : neuron
		reluNeuron #(
			.InputCount(InputCount),
			.Weights(Weights[n*InputCount*DataWidth +: InputCount*DataWidth]),
			.Bias(Biases[n*BiasWidth +: BiasWidth])
		) node (
			.clk(clk),
			.reset(reset),
			.activations(activations),
			.activation(outActivations[n*DataWidth +: DataWidth])
		);
	end

	// One valid bit per item in flight through the neuron stages
	always_ff @(posedge clk)
	begin
		if (reset)
			validPipe <= '0;
		else
			validPipe <= {validPipe[NeuronLatency-2:0], inValid};
	end

	assign outValid = validPipe[NeuronLatency-1];

endmodule

// ==== verilog/mlpAccelTop.sv ====
`timescale 1ns/1ps

module mlpAccelTop
	import nnFormatPkg::*, axiLiteRegPkg::*;
#(
	// Neuron 3 is listed first, and within a neuron the highest input comes first
	parameter logic [HiddenCount*InputCount*DataWidth-1:0] HiddenWeights = {
		8'sd18, 8'sd2, -8'sd7, 8'sd28, 8'sd13, -8'sd4, 8'sd19, -8'sd25, 8'sd6, 8'sd6,
		-8'sd9, 8'sd14, 8'sd10, -8'sd20, 8'sd5, 8'sd17, 8'sd8, -8'sd3, 8'sd30, -8'sd12,
		8'sd7, -8'sd6, 8'sd25, 8'sd3, -8'sd14, 8'sd9, 8'sd11, 8'sd4, -8'sd8, 8'sd20,
		8'sd12, -8'sd31, -8'sd31, 8'sd22, 8'sd27, -8'sd31, 8'sd15, 8'sd16, 8'sd2, -8'sd5
	},
	parameter logic [HiddenCount*BiasWidth-1:0] HiddenBiases = {
		-16'sd128, 16'sd64, 16'sd256, -16'sd512
	},
	parameter logic [OutputCount*HiddenCount*DataWidth-1:0] OutputWeights = {
		-8'sd16, 8'sd12, 8'sd45, -8'sd30,
		8'sd18, 8'sd35, -8'sd22, 8'sd40
	},
	parameter logic [OutputCount*BiasWidth-1:0] OutputBiases = {
		-16'sd64, 16'sd100
	}
)
(
	input logic clk,
	input logic reset,
	input logic [AddrWidth-1:0] awaddr,
	input logic awvalid,
	output logic awready,
	input logic [BusWidth-1:0] wdata,
	input logic [BusWidth/8-1:0] wstrb,
	input logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,
	input logic [AddrWidth-1:0] araddr,
	input logic arvalid,
	output logic arready,
	output logic [BusWidth-1:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready
);

	logic [InputCount*DataWidth-1:0] netInputs;
	logic netInValid;
	logic [HiddenCount*DataWidth-1:0] hiddenOut;
	logic hiddenValid;
	logic [OutputCount*DataWidth-1:0] netOutputs;
	logic netOutValid;

	axiLiteRegs regs (
		.clk(clk), .reset(reset),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.netInputs(netInputs), .inValid(netInValid),
		.netOutputs(netOutputs), .outValid(netOutValid)
	);

	denseLayer #(
		.InputCount(InputCount),
		.NeuronCount(HiddenCount),
		.Weights(HiddenWeights),
		.Biases(HiddenBiases)
	) hiddenLayer (
		.clk(clk), .reset(reset),
		.activations(netInputs), .inValid(netInValid),
		.outActivations(hiddenOut), .outValid(hiddenValid)
	);

	denseLayer #(
		.InputCount(HiddenCount),
		.NeuronCount(OutputCount),
		.Weights(OutputWeights),
		.Biases(OutputBiases)
	) outputLayer (
		.clk(clk), .reset(reset),
		.activations(hiddenOut), .inValid(hiddenValid),
		.outActivations(netOutputs), .outValid(netOutValid)
	);

endmodule

// ==== verilog/nnFormatPkg.sv ====
package nnFormatPkg;

	// Activations and weights are signed bytes
	localparam int DataWidth = 8;

	localparam int BiasWidth = 16;

	// Ten 16-bit products plus a 16-bit bias fit in 23 bits without overflow
	localparam int AccWidth = 23;

	// Activations are Q1.6 fixed point
	localparam int FracBits = 6;

	// ReLU output ceiling
	localparam int ActMax = 127;

	// Network shape
	localparam int InputCount = 10;
	localparam int HiddenCount = 4;
	localparam int OutputCount = 2;

	// Input register, accumulate and activation stages
	localparam int NeuronLatency = 3;

endpackage

// ==== verilog/reluNeuron.sv ====
`timescale 1ns/1ps

module reluNeuron
	import nnFormatPkg::*;
#(
	parameter int InputCount = nnFormatPkg::InputCount,
	parameter logic [InputCount*DataWidth-1:0] Weights = '0,
	parameter logic signed [BiasWidth-1:0] Bias = '0
)
(
	input logic clk,
	input logic reset,
	input logic [InputCount*DataWidth-1:0] activations,
	output logic [DataWidth-1:0] activation
);

	// Top bit of the integer window that becomes the output byte
	localparam int IntTop = FracBits + DataWidth - 1;

	logic signed [DataWidth-1:0] actReg [InputCount];
	logic signed [2*DataWidth-1:0] products [InputCount];
	logic signed [AccWidth-1:0] accSum;
	logic signed [AccWidth-1:0] acc;
	logic roundUp;
	logic [DataWidth:0] rounded;

	always_comb
	begin
		for (int i = 0; i < InputCount; i++)
			products[i] = actReg[i] * signed'(Weights[i*DataWidth +: DataWidth]);
	end

	always_comb
	begin
		accSum = AccWidth'(Bias);
		for (int i = 0; i < InputCount; i++)
			accSum += products[i];
	end

	// Exact half rounds down, anything above half rounds up
	assign roundUp = acc[FracBits-1] && (|acc[FracBits-2:0]);
	assign rounded = {1'b0, acc[IntTop -: DataWidth]} + (DataWidth+1)'(roundUp);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < InputCount; i++)
				actReg[i] <= '0;
			acc <= '0;
			activation <= '0;
		end
		else
		begin
			for (int i = 0; i < InputCount; i++)
				actReg[i] <= activations[i*DataWidth +: DataWidth];
			acc <= accSum;
			if (acc[AccWidth-1])
				activation <= '0;
			else if (|acc[AccWidth-2:IntTop])
				activation <= DataWidth'(ActMax);
			// Rounding 127.5 and up would otherwise wrap to 128
			else if (rounded > (DataWidth+1)'(ActMax))
				activation <= DataWidth'(ActMax);
			else
				activation <= rounded[DataWidth-1:0];
		end
	end

endmodule
